/* project.f */
hw/rbm_check_pkg.sv
hw/impl_write_capture.sv
hw/gm_write_capture.sv
hw/record_compare.sv
hw/mismatch_collector.sv
hw/rbm_write_checker.sv
verif/rbm_write_checker_asserts.sv
verif/tb_rbm_write_checker.sv

/* run_sim.sh */
#!/bin/sh
# Builds the checker testbench with Verilator, runs it and
# reports failure through the exit status.

set -u

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_rbm_write_checker -f project.f \
  --Mdir obj_dir -o sim_tb > "$build_log" 2>&1
status=$?
cat "$build_log"
if [ "$status" -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

# let assertion errors accumulate so the testbench can count them
./obj_dir/sim_tb +verilator+error+limit+1000 > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAIL" "$sim_log"; then
  exit 1
fi
exit 0

/* verif/tb_rbm_write_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the RBM write-trace checker.
// Each test resets the DUT, writes both record sides,
// strobes a compare and checks the summary outputs.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module tb_rbm_write_checker;

  import rbm_check_pkg::*;

  localparam int clk_period = 20;
  localparam int num_tests = 6;
  localparam int cycles_per_test = 100;
  localparam int watchdog_ns = (num_tests * cycles_per_test + 100) * clk_period;
  // bank offsets of the golden model
  localparam logic [9:0] data_offset = 10'd501;
  localparam logic [9:0] result_offset = 10'd100;

  logic CLK;
  logic RST;
  logic impl_rec;
  logic data_ce;
  logic data_we;
  logic [9:0] data_addr;
  logic [7:0] data_wdata;
  logic result_ce;
  logic result_we;
  logic [6:0] result_addr;
  logic [3:0] result_wdata;
  logic gm_step;
  logic gm_sel;
  logic gm_compare;
  logic gm_data_wen;
  logic [8:0] gm_data_addr;
  logic [7:0] gm_data_wdata;
  logic gm_result_wen;
  logic [5:0] gm_result_addr;
  logic [3:0] gm_result_wdata;
  logic mismatch;
  logic mismatch_seen;
  buf_id_t first_fail;

  int errors = 0;
  int checks = 0;
  int assert_fails;
  logic [31:0] lfsr;
  logic [31:0] r;
  logic [8:0] da;
  logic [7:0] dv;
  logic [5:0] ra;
  logic [3:0] rv;

  rbm_write_checker u_rbm_write_checker (
    .CLK             (CLK),
    .RST             (RST),
    .impl_rec        (impl_rec),
    .data_ce         (data_ce),
    .data_we         (data_we),
    .data_addr       (data_addr),
    .data_wdata      (data_wdata),
    .result_ce       (result_ce),
    .result_we       (result_we),
    .result_addr     (result_addr),
    .result_wdata    (result_wdata),
    .gm_step         (gm_step),
    .gm_sel          (gm_sel),
    .gm_compare      (gm_compare),
    .gm_data_wen     (gm_data_wen),
    .gm_data_addr    (gm_data_addr),
    .gm_data_wdata   (gm_data_wdata),
    .gm_result_wen   (gm_result_wen),
    .gm_result_addr  (gm_result_addr),
    .gm_result_wdata (gm_result_wdata),
    .mismatch        (mismatch),
    .mismatch_seen   (mismatch_seen),
    .first_fail      (first_fail)
  );

  always #(clk_period / 2) CLK = ~CLK;

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      bits = {bits[30:0], lfsr[0]};
    end
  endtask

  task automatic apply_reset();
    @(posedge CLK);
    #2;
    RST = 1'b1;
    repeat (10) @(posedge CLK);
    #2;
    RST = 1'b0;
  endtask

  task automatic acc_write(input logic to_result, input logic rec, input logic [9:0] a,
                           input logic [7:0] v);
    @(posedge CLK);
    #2;
    impl_rec = rec;
    if (to_result) begin
      result_ce = 1'b1;
      result_we = 1'b1;
      result_addr = a[6:0];
      result_wdata = v[3:0];
    end else begin
      data_ce = 1'b1;
      data_we = 1'b1;
      data_addr = a;
      data_wdata = v;
    end
    @(posedge CLK);
    #2;
    impl_rec = 1'b0;
    data_ce = 1'b0;
    data_we = 1'b0;
    result_ce = 1'b0;
    result_we = 1'b0;
  endtask

  task automatic gm_write(input logic to_result, input logic step, input logic sel,
                          input logic [8:0] a, input logic [7:0] v);
    @(posedge CLK);
    #2;
    gm_step = step;
    gm_sel = sel;
    if (to_result) begin
      gm_result_wen = 1'b1;
      gm_result_addr = a[5:0];
      gm_result_wdata = v[3:0];
    end else begin
      gm_data_wen = 1'b1;
      gm_data_addr = a;
      gm_data_wdata = v;
    end
    @(posedge CLK);
    #2;
    gm_step = 1'b0;
    gm_data_wen = 1'b0;
    gm_result_wen = 1'b0;
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // strobe at edge E, result pulse in the cycle after edge E+1
  task automatic compare_expect(input logic exp_mm, input logic exp_seen,
                                input buf_id_t exp_ff);
    @(posedge CLK);
    #2;
    gm_compare = 1'b1;
    @(posedge CLK);
    #2;
    gm_compare = 1'b0;
    check_bit(mismatch, 1'b0, "mismatch one cycle after strobe");
    @(posedge CLK);
    #2;
    check_bit(mismatch, exp_mm, "mismatch two cycles after strobe");
    check_bit(mismatch_seen, exp_seen, "mismatch_seen");
    check_bit(first_fail, exp_ff, "first_fail");
    @(posedge CLK);
    #2;
    check_bit(mismatch, 1'b0, "mismatch three cycles after strobe");
  endtask

  task automatic reset_clean_compare();
    apply_reset();
    check_bit(mismatch_seen, 1'b0, "mismatch_seen after reset");
    check_bit(first_fail, buf_data, "first_fail after reset");
    compare_expect(1'b0, 1'b0, buf_data);
  endtask

  task automatic matching_writes();
    apply_reset();
    take_bits(9, r);
    da = r[8:0];
    take_bits(8, r);
    dv = r[7:0];
    take_bits(6, r);
    ra = r[5:0];
    take_bits(4, r);
    rv = r[3:0];
    acc_write(1'b0, 1'b1, {1'b0, da}, dv);
    gm_write(1'b0, 1'b1, 1'b0, da, dv);
    acc_write(1'b1, 1'b1, {4'b0, ra}, {4'b0, rv});
    gm_write(1'b1, 1'b1, 1'b0, {3'b0, ra}, {4'b0, rv});
    compare_expect(1'b0, 1'b0, buf_data);
  endtask

  task automatic bank_mapping();
    apply_reset();
    take_bits(9, r);
    da = r[8:0];
    take_bits(8, r);
    dv = r[7:0];
    // small result address so a+100 stays inside 7 bits
    take_bits(4, r);
    ra = {2'b00, r[3:0]};
    take_bits(4, r);
    rv = r[3:0];
    acc_write(1'b0, 1'b1, {1'b0, da} + data_offset, dv);
    gm_write(1'b0, 1'b1, 1'b1, da, dv);
    acc_write(1'b1, 1'b1, {4'b0, ra} + result_offset, {4'b0, rv});
    gm_write(1'b1, 1'b1, 1'b1, {3'b0, ra}, {4'b0, rv});
    compare_expect(1'b0, 1'b0, buf_data);
    // lower bank on the result side only
    gm_write(1'b1, 1'b1, 1'b0, {3'b0, ra}, {4'b0, rv});
    compare_expect(1'b1, 1'b1, buf_result);
    // result matches again, data now in the lower bank
    gm_write(1'b1, 1'b1, 1'b1, {3'b0, ra}, {4'b0, rv});
    gm_write(1'b0, 1'b1, 1'b0, da, dv);
    compare_expect(1'b1, 1'b1, buf_result);
  endtask

  task automatic result_difference();
    apply_reset();
    take_bits(6, r);
    ra = r[5:0];
    take_bits(4, r);
    rv = r[3:0];
    acc_write(1'b1, 1'b1, {4'b0, ra}, {4'b0, rv});
    gm_write(1'b1, 1'b1, 1'b0, {3'b0, ra}, {4'b0, rv ^ 4'h1});
    compare_expect(1'b1, 1'b1, buf_result);
    // one side only
    apply_reset();
    acc_write(1'b1, 1'b1, {4'b0, ra}, {4'b0, rv});
    compare_expect(1'b1, 1'b1, buf_result);
  endtask

  task automatic gating_overwrite();
    apply_reset();
    take_bits(9, r);
    da = r[8:0];
    take_bits(8, r);
    dv = r[7:0];
    acc_write(1'b0, 1'b0, {1'b0, da}, dv);
    gm_write(1'b0, 1'b0, 1'b0, da ^ 9'h1, dv);
    compare_expect(1'b0, 1'b0, buf_data);
    acc_write(1'b0, 1'b1, {1'b0, da}, dv);
    gm_write(1'b0, 1'b1, 1'b0, da ^ 9'h1, dv ^ 8'h80);
    acc_write(1'b0, 1'b1, {1'b0, da ^ 9'h2}, dv ^ 8'h3c);
    gm_write(1'b0, 1'b1, 1'b0, da ^ 9'h2, dv ^ 8'h3c);
    // gated writes must leave the matching records alone
    acc_write(1'b0, 1'b0, {1'b0, da}, dv);
    gm_write(1'b0, 1'b0, 1'b0, da ^ 9'h4, dv);
    compare_expect(1'b0, 1'b0, buf_data);
  endtask

  task automatic priority_sticky();
    apply_reset();
    take_bits(9, r);
    da = r[8:0];
    take_bits(8, r);
    dv = r[7:0];
    take_bits(6, r);
    ra = r[5:0];
    take_bits(4, r);
    rv = r[3:0];
    acc_write(1'b0, 1'b1, {1'b0, da}, dv);
    gm_write(1'b0, 1'b1, 1'b0, da, dv ^ 8'h01);
    acc_write(1'b1, 1'b1, {4'b0, ra}, {4'b0, rv});
    compare_expect(1'b1, 1'b1, buf_data);
    gm_write(1'b0, 1'b1, 1'b0, da, dv);
    gm_write(1'b1, 1'b1, 1'b0, {3'b0, ra}, {4'b0, rv});
    compare_expect(1'b0, 1'b1, buf_data);
  endtask

  initial begin
    CLK = 1'b0;
    RST = 1'b1;
    impl_rec = 1'b0;
    data_ce = 1'b0;
    data_we = 1'b0;
    data_addr = '0;
    data_wdata = '0;
    result_ce = 1'b0;
    result_we = 1'b0;
    result_addr = '0;
    result_wdata = '0;
    gm_step = 1'b0;
    gm_sel = 1'b0;
    gm_compare = 1'b0;
    gm_data_wen = 1'b0;
    gm_data_addr = '0;
    gm_data_wdata = '0;
    gm_result_wen = 1'b0;
    gm_result_addr = '0;
    gm_result_wdata = '0;
    lfsr = 32'hd85d1fa7;
    reset_clean_compare();
    matching_writes();
    bank_mapping();
    result_difference();
    gating_overwrite();
    priority_sticky();
    assert_fails = u_rbm_write_checker.u_asserts.fail_count;
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("timeout: the directed tests did not finish within %0d ns", watchdog_ns);
    $display("TEST FAIL");
    $finish;
  end

endmodule

/* verif/rbm_write_checker_asserts.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Concurrent checks on the summary outputs of the
// write-trace checker. Bound into every instance of
// the top level, failures are counted in fail_count.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module rbm_write_checker_asserts (
  input logic CLK,
  input logic RST,
  input logic gm_compare,
  input logic mismatch,
  input logic mismatch_seen
);

  int fail_count = 0;

  // every pulse cycle traces back to a strobe two edges earlier
  a_pulse_has_strobe: assert property (
    @(posedge CLK) disable iff (RST) mismatch |-> $past(gm_compare, 2)
  ) else begin
    $error("mismatch high without a compare strobe two cycles earlier");
    fail_count++;
  end

  a_seen_sticky: assert property (
    @(posedge CLK) disable iff (RST) !$fell(mismatch_seen)
  ) else begin
    $error("mismatch_seen cleared outside reset");
    fail_count++;
  end

  a_pulse_sets_seen: assert property (
    @(posedge CLK) disable iff (RST) mismatch |-> mismatch_seen
  ) else begin
    $error("mismatch high while mismatch_seen is low");
    fail_count++;
  end

endmodule

bind rbm_write_checker rbm_write_checker_asserts u_asserts (
  .CLK           (CLK),
  .RST           (RST),
  .gm_compare    (gm_compare),
  .mismatch      (mismatch),
  .mismatch_seen (mismatch_seen)
);

/* hw/rbm_write_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Write-trace checker for the data and predict_result
// buffers of the RBM accelerator. Each buffer has an
// accelerator record, a golden-model record and a
// compare stage. A gm_compare strobe yields mismatch
// two edges later; mismatch_seen and first_fail hold
// the summary until reset.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module rbm_write_checker (
  input  logic                                   CLK,
  input  logic                                   RST,
  // accelerator side
  input  logic                                   impl_rec,
  input  logic                                   data_ce,
  input  logic                                   data_we,
  input  logic [rbm_check_pkg::data_addr_w-1:0]  data_addr,
  input  rbm_check_pkg::pixel_t                  data_wdata,
  input  logic                                   result_ce,
  input  logic                                   result_we,
  input  logic [rbm_check_pkg::result_addr_w-1:0] result_addr,
  input  rbm_check_pkg::rating_t                 result_wdata,
  // golden-model side
  input  logic                                   gm_step,
  input  logic                                   gm_sel,
  input  logic                                   gm_compare,
  input  logic                                   gm_data_wen,
  input  logic [rbm_check_pkg::data_gm_addr_w-1:0] gm_data_addr,
  input  rbm_check_pkg::pixel_t                  gm_data_wdata,
  input  logic                                   gm_result_wen,
  input  logic [rbm_check_pkg::result_gm_addr_w-1:0] gm_result_addr,
  input  rbm_check_pkg::rating_t                 gm_result_wdata,
  // summary
  output logic                                   mismatch,
  output logic                                   mismatch_seen,
  output rbm_check_pkg::buf_id_t                 first_fail
);

  import rbm_check_pkg::*;

  logic                     data_impl_dirty;
  logic [data_addr_w-1:0]   data_impl_addr;
  pixel_t                   data_impl_value;
  logic                     data_gm_dirty;
  logic [data_addr_w-1:0]   data_gm_addr;
  pixel_t                   data_gm_value;
  logic                     data_mismatch;

  logic                     result_impl_dirty;
  logic [result_addr_w-1:0] result_impl_addr;
  rating_t                  result_impl_value;
  logic                     result_gm_dirty;
  logic [result_addr_w-1:0] result_gm_addr;
  rating_t                  result_gm_value;
  logic                     result_mismatch;

  // visible-unit data
  impl_write_capture #(.ADDR_W(data_addr_w), .value_t(pixel_t)) u_data_impl (
    .CLK       (CLK),
    .RST       (RST),
    .impl_rec  (impl_rec),
    .ce        (data_ce),
    .we        (data_we),
    .addr      (data_addr),
    .wdata     (data_wdata),
    .rec_dirty (data_impl_dirty),
    .rec_addr  (data_impl_addr),
    .rec_value (data_impl_value)
  );

  gm_write_capture #(
    .GM_ADDR_W   (data_gm_addr_w),
    .ADDR_W      (data_addr_w),
    .BANK_OFFSET (data_bank_offset),
    .value_t     (pixel_t)
  ) u_data_gm (
    .CLK       (CLK),
    .RST       (RST),
    .gm_step   (gm_step),
    .wen       (gm_data_wen),
    .bank_sel  (gm_sel),
    .addr      (gm_data_addr),
    .wdata     (gm_data_wdata),
    .rec_dirty (data_gm_dirty),
    .rec_addr  (data_gm_addr),
    .rec_value (data_gm_value)
  );

  record_compare #(.ADDR_W(data_addr_w), .value_t(pixel_t)) u_data_cmp (
    .CLK          (CLK),
    .RST          (RST),
    .compare      (gm_compare),
    .impl_dirty   (data_impl_dirty),
    .impl_addr    (data_impl_addr),
    .impl_value   (data_impl_value),
    .gm_dirty     (data_gm_dirty),
    .gm_addr      (data_gm_addr),
    .gm_value     (data_gm_value),
    .buf_mismatch (data_mismatch)
  );

  // predicted ratings
  impl_write_capture #(.ADDR_W(result_addr_w), .value_t(rating_t)) u_result_impl (
    .CLK       (CLK),
    .RST       (RST),
    .impl_rec  (impl_rec),
    .ce        (result_ce),
    .we        (result_we),
    .addr      (result_addr),
    .wdata     (result_wdata),
    .rec_dirty (result_impl_dirty),
    .rec_addr  (result_impl_addr),
    .rec_value (result_impl_value)
  );

  gm_write_capture #(
    .GM_ADDR_W   (result_gm_addr_w),
    .ADDR_W      (result_addr_w),
    .BANK_OFFSET (result_bank_offset),
    .value_t     (rating_t)
  ) u_result_gm (
    .CLK       (CLK),
    .RST       (RST),
    .gm_step   (gm_step),
    .wen       (gm_result_wen),
    .bank_sel  (gm_sel),
    .addr      (gm_result_addr),
    .wdata     (gm_result_wdata),
    .rec_dirty (result_gm_dirty),
    .rec_addr  (result_gm_addr),
    .rec_value (result_gm_value)
  );

  record_compare #(.ADDR_W(result_addr_w), .value_t(rating_t)) u_result_cmp (
    .CLK          (CLK),
    .RST          (RST),
    .compare      (gm_compare),
    .impl_dirty   (result_impl_dirty),
    .impl_addr    (result_impl_addr),
    .impl_value   (result_impl_value),
    .gm_dirty     (result_gm_dirty),
    .gm_addr      (result_gm_addr),
    .gm_value     (result_gm_value),
    .buf_mismatch (result_mismatch)
  );

  mismatch_collector u_collect (
    .CLK             (CLK),
    .RST             (RST),
    .data_mismatch   (data_mismatch),
    .result_mismatch (result_mismatch),
    .mismatch        (mismatch),
    .mismatch_seen   (mismatch_seen),
    .first_fail      (first_fail)
  );

endmodule

/* hw/mismatch_collector.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Merges the per-buffer compare results. Gives a
// one-cycle mismatch pulse, a flag that stays set until
// reset, and the id of the buffer that failed first.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module mismatch_collector (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   data_mismatch,
  input  logic                   result_mismatch,
  output logic                   mismatch,
  output logic                   mismatch_seen,
  output rbm_check_pkg::buf_id_t first_fail
);

  import rbm_check_pkg::*;

  logic    any_mismatch;
  buf_id_t fail_id;

  assign any_mismatch = data_mismatch | result_mismatch;

  // data has priority when both fail in one compare
  assign fail_id = data_mismatch ? buf_data : buf_result;

  always_ff @(posedge CLK) begin
    if (RST) begin
      mismatch <= 1'b0;
    end else begin
      mismatch <= any_mismatch;
    end
  end

  always_ff @(posedge CLK) begin
    if (RST) begin
      mismatch_seen <= 1'b0;
    end else if (any_mismatch) begin
      mismatch_seen <= 1'b1;
    end
  end

  // latched once, later failures leave it alone
  always_ff @(posedge CLK) begin
    if (RST) begin
      first_fail <= buf_data;
    end else if (any_mismatch && !mismatch_seen) begin
      first_fail <= fail_id;
    end
  end

endmodule

/* hw/record_compare.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Compares the accelerator and golden-model records
// of one buffer when the compare strobe arrives. The
// result is registered and is a one-cycle pulse.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module record_compare #(
  parameter int ADDR_W = rbm_check_pkg::data_addr_w,
  parameter type value_t = rbm_check_pkg::pixel_t
) (
  input  logic              CLK,
  input  logic              RST,
  input  logic              compare,
  input  logic              impl_dirty,
  input  logic [ADDR_W-1:0] impl_addr,
  input  value_t            impl_value,
  input  logic              gm_dirty,
  input  logic [ADDR_W-1:0] gm_addr,
  input  value_t            gm_value,
  output logic              buf_mismatch
);

  import rbm_check_pkg::*;

  logic dirty_diff;
  logic both_dirty;
  logic payload_diff;
  logic rec_diff;

  // only one side has written
  assign dirty_diff = impl_dirty ^ gm_dirty;
  assign both_dirty = impl_dirty & gm_dirty;

  assign payload_diff = (impl_addr != gm_addr) || (impl_value != gm_value);

  // two clean records match, payload of a clean record is don't care
  assign rec_diff = dirty_diff | (both_dirty & payload_diff);

  // records are register outputs, so a write on the strobe edge
  // is not part of this compare
  always_ff @(posedge CLK) begin
    if (RST) begin
      buf_mismatch <= 1'b0;
    end else begin
      buf_mismatch <= compare & rec_diff;
    end
  end

endmodule

/* hw/gm_write_capture.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Keeps the last golden-model write to one buffer.
// The golden model addresses one of two banks, so the
// address is mapped into accelerator space before it
// is stored. Writes count only on a gm_step cycle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module gm_write_capture #(
  parameter int GM_ADDR_W = rbm_check_pkg::data_gm_addr_w,
  parameter int ADDR_W = rbm_check_pkg::data_addr_w,
  parameter int BANK_OFFSET = rbm_check_pkg::data_bank_offset,
  parameter type value_t = rbm_check_pkg::pixel_t
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 gm_step,
  input  logic                 wen,
  input  logic                 bank_sel,
  input  logic [GM_ADDR_W-1:0] addr,
  input  value_t               wdata,
  output logic                 rec_dirty,
  output logic [ADDR_W-1:0]    rec_addr,
  output value_t               rec_value
);

  import rbm_check_pkg::*;

  localparam logic [ADDR_W-1:0] offset_c = ADDR_W'(BANK_OFFSET);

  logic [ADDR_W-1:0] addr_ext;
  logic [ADDR_W-1:0] addr_map;
  logic              wr_hit;

  assign addr_ext = {{(ADDR_W - GM_ADDR_W){1'b0}}, addr};
  // upper bank sits at a fixed offset, sum wraps at ADDR_W bits
  assign addr_map = bank_sel ? addr_ext + offset_c : addr_ext;
  assign wr_hit = gm_step & wen;

  always_ff @(posedge CLK) begin
    if (RST) begin
      rec_dirty <= 1'b0;
    end else if (wr_hit) begin
      rec_dirty <= 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (wr_hit) begin
      rec_addr  <= addr_map;
      rec_value <= wdata;
    end
  end

endmodule

/* hw/impl_write_capture.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Keeps the last write the accelerator made to one
// buffer. A write counts only while impl_rec is high.
// One instance per buffer, widths set by the top level.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module impl_write_capture #(
  parameter int ADDR_W = rbm_check_pkg::data_addr_w,
  parameter type value_t = rbm_check_pkg::pixel_t
) (
  input  logic              CLK,
  input  logic              RST,
  input  logic              impl_rec,
  input  logic              ce,
  input  logic              we,
  input  logic [ADDR_W-1:0] addr,
  input  value_t            wdata,
  output logic              rec_dirty,
  output logic [ADDR_W-1:0] rec_addr,
  output value_t            rec_value
);

  import rbm_check_pkg::*;

  logic wr_hit;

  // recording window and a real write strobe
  assign wr_hit = impl_rec & ce & we;

  always_ff @(posedge CLK) begin
    if (RST) begin
      rec_dirty <= 1'b0;
    end else if (wr_hit) begin
      rec_dirty <= 1'b1;
    end
  end

  // last write wins, older entries are dropped
  always_ff @(posedge CLK) begin
    if (wr_hit) begin
      rec_addr  <= addr;
      rec_value <= wdata;
    end
  end

endmodule

/* hw/rbm_check_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, bank offsets and value types for the
// RBM write-trace checker. Compile this package before
// any of the checker modules.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package rbm_check_pkg;

  // visible-unit data buffer
  localparam int data_addr_w = 10;
  localparam int data_gm_addr_w = 9;
  // upper golden-model bank starts after the first 501 visible units
  localparam int data_bank_offset = 501;

  // predicted ratings buffer
  localparam int result_addr_w = 7;
  localparam int result_gm_addr_w = 6;
  // upper bank starts after 100 movies
  localparam int result_bank_offset = 100;

  // stored values
  typedef logic [7:0] pixel_t;
  typedef logic [3:0] rating_t;

  // buffer ids, also the encoding of first_fail
  typedef logic buf_id_t;

  localparam buf_id_t buf_data = 1'b0;
  localparam buf_id_t buf_result = 1'b1;

endpackage
